//--- hw/burst_test_pkg.sv
////////////////////////////////////////
// Shared constants for the burst test path
// Wishbone burst request and response structs
// Pattern word union, control and status words
////////////////////////////////////////

package burst_test_pkg;

    ////////////////////////////////////////
    // Burst geometry
    ////////////////////////////////////////

    // Beats per burst, one 64-bit word each
    localparam int BURST_LEN = 512;
    localparam int BEAT_W = $clog2(BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

    // Number of burst sources on the shared bus
    localparam int CHAN_COUNT = 2;
    localparam int CHAN_W = $clog2(CHAN_COUNT);

    // Beat corrupted by data fault injection
    localparam int FAULT_BEAT = 100;

    // Cycle type codes
    localparam logic [2:0] CTI_INC = 3'b001;
    localparam logic [2:0] CTI_END = 3'b111;

    // Linear burst, full 64-bit lane
    localparam logic [1:0] BTE_LINEAR = 2'b00;
    localparam logic [7:0] SEL_ALL = 8'hFF;

    ////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////

    // Master to bus, 92 bits
    typedef struct packed {
        logic [11:0] adr;
        logic [63:0] dat;
        logic [7:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
        logic [2:0]  cti;
        logic [1:0]  bte;
    } wb_req_t;

    // Bus to master
    typedef struct packed {
        logic ack;
        logic err;
    } wb_rsp_t;

    // Fields of a self-describing data word
    typedef struct packed {
        logic [7:0]  chan_tag;
        logic [23:0] burst_num;
        logic [31:0] beat_idx;
    } pattern_fields_t;

    // Same word seen as bus data or as pattern fields
    typedef union packed {
        logic [63:0]     raw;
        pattern_fields_t pat;
    } pattern_word_u;

    // Word forwarded by the check slave
    typedef struct packed {
        logic        ena;
        logic [63:0] dat;
    } check_data_t;

    ////////////////////////////////////////
    // Control and status
    ////////////////////////////////////////

    typedef struct packed {
        logic check_en;
        logic fault_chan;
        logic inj_data;
        logic inj_cti;
    } test_ctrl_t;

    typedef struct packed {
        logic [31:0] word_cnt;
        logic [15:0] data_err_cnt;
        logic [15:0] prot_err_cnt;
    } test_status_t;

endpackage

//--- hw/burst_source.sv
////////////////////////////////////////
// Burst source for the Wishbone burst bus
// One pattern burst per start pulse
// Optional data and cycle type fault injection
////////////////////////////////////////
`timescale 1ns/100ps

module burst_source #(
    parameter int CHAN_ID = 0
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    input  burst_test_pkg::test_ctrl_t   i_ctrl,
    input  logic                         i_grant,
    input  burst_test_pkg::wb_rsp_t      i_rsp,
    output burst_test_pkg::wb_req_t      o_req,
    output logic                         o_done
);

    // Bus strobes, cycle doubles as the arbiter request
    logic cyc_q;
    logic stb_q;
    // Beat within burst and running burst number
    logic [burst_test_pkg::BEAT_W-1:0] beat_q;
    logic [23:0] burst_q;
    logic done_q;

    logic beat_ok;
    logic last_beat;
    logic fault_here;
    burst_test_pkg::pattern_word_u word;

    // Beat completes only while we own the bus
    assign beat_ok = i_grant && stb_q && i_rsp.ack;
    assign last_beat = (beat_q == burst_test_pkg::LAST_BEAT);
    // Fault injection targets one channel only
    assign fault_here = (int'(i_ctrl.fault_chan) == CHAN_ID);

    ////////////////////////////////////////
    // Pattern word and request
    ////////////////////////////////////////
    always_comb
    begin
        word.pat.chan_tag = 8'(CHAN_ID);
        word.pat.burst_num = burst_q;
        word.pat.beat_idx = 32'(beat_q);
        // Corrupt one beat index bit
        if (fault_here && i_ctrl.inj_data && int'(beat_q) == burst_test_pkg::FAULT_BEAT)
        begin
            word.pat.beat_idx[0] = ~word.pat.beat_idx[0];
        end
    end

    always_comb
    begin
        // Constant address burst from base zero
        o_req.adr = '0;
        o_req.dat = word.raw;
        o_req.sel = burst_test_pkg::SEL_ALL;
        o_req.we = 1'b1;
        o_req.cyc = cyc_q;
        o_req.stb = stb_q;
        o_req.bte = burst_test_pkg::BTE_LINEAR;
        if (last_beat && !(fault_here && i_ctrl.inj_cti))
        begin
            o_req.cti = burst_test_pkg::CTI_END;
        end
        else
        begin
            // Also the faulted last beat
            o_req.cti = burst_test_pkg::CTI_INC;
        end
    end

    ////////////////////////////////////////
    // Burst sequencing
    ////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            beat_q <= '0;
            burst_q <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!cyc_q)
            begin
                // Idle, start ignored otherwise
                if (i_start)
                begin
                    cyc_q <= 1'b1;
                    stb_q <= 1'b1;
                    beat_q <= '0;
                end
            end
            else if (beat_ok)
            begin
                if (last_beat)
                begin
                    cyc_q <= 1'b0;
                    stb_q <= 1'b0;
                    burst_q <= burst_q + 24'd1;
                    done_q <= 1'b1;
                end
                else
                begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    assign o_done = done_q;

    // Strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_req.stb |-> o_req.cyc);

endmodule

//--- hw/burst_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter for the burst bus
// Grants whole cycles, muxes requests and routes responses
////////////////////////////////////////
`timescale 1ns/100ps

module burst_arbiter (
    input  logic                                                    i_clk,
    input  logic                                                    i_rst,
    input  burst_test_pkg::wb_req_t [burst_test_pkg::CHAN_COUNT-1:0] i_req,
    output logic [burst_test_pkg::CHAN_COUNT-1:0]                   o_grant,
    output burst_test_pkg::wb_req_t                                 o_req,
    input  burst_test_pkg::wb_rsp_t                                 i_rsp,
    output burst_test_pkg::wb_rsp_t [burst_test_pkg::CHAN_COUNT-1:0] o_rsp
);

    // Registered one-hot grant
    logic [burst_test_pkg::CHAN_COUNT-1:0] grant_q;
    // Channel served most recently
    logic [burst_test_pkg::CHAN_W-1:0] last_q;

    logic [burst_test_pkg::CHAN_COUNT-1:0] req_lvl;
    logic [burst_test_pkg::CHAN_COUNT-1:0] pick;
    logic [burst_test_pkg::CHAN_W-1:0] pick_idx;
    logic owner_cyc;

    always_comb
    begin
        for (int i = 0; i < burst_test_pkg::CHAN_COUNT; i++)
        begin
            req_lvl[i] = i_req[i].cyc;
        end
    end

    // Owner still inside its cycle
    assign owner_cyc = |(grant_q & req_lvl);

    ////////////////////////////////////////
    // Next owner search
    ////////////////////////////////////////
    always_comb
    begin
        int idx;
        logic found;
        pick = '0;
        pick_idx = last_q;
        found = 1'b0;
        // Start one past the last served channel
        for (int k = 1; k <= burst_test_pkg::CHAN_COUNT; k++)
        begin
            idx = (int'(last_q) + k) % burst_test_pkg::CHAN_COUNT;
            if (!found && req_lvl[idx])
            begin
                pick[idx] = 1'b1;
                pick_idx = idx[burst_test_pkg::CHAN_W-1:0];
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            grant_q <= '0;
            last_q <= '0;
        end
        else if (|grant_q)
        begin
            // Release the cycle after the owner drops cyc
            if (!owner_cyc)
            begin
                grant_q <= '0;
            end
        end
        else if (|req_lvl)
        begin
            grant_q <= pick;
            last_q <= pick_idx;
        end
    end

    assign o_grant = grant_q;

    ////////////////////////////////////////
    // Bus multiplexing
    ////////////////////////////////////////
    always_comb
    begin
        // Idle bus when nobody owns it
        o_req = '0;
        for (int i = 0; i < burst_test_pkg::CHAN_COUNT; i++)
        begin
            if (grant_q[i])
            begin
                o_req = i_req[i];
            end
            // Losers see ack and err low
            o_rsp[i] = grant_q[i] ? i_rsp : '0;
        end
    end

    a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(grant_q));
    a_grant_locked: assert property (@(posedge i_clk) disable iff (i_rst)
        (|grant_q) && o_req.cyc |=> $stable(grant_q));

endmodule

//--- hw/check_burst_slave.sv
////////////////////////////////////////
// Write-only check slave on the burst bus
// Acks valid 64-bit beats, flags cycle type faults
// Forwards accepted words with an enable
////////////////////////////////////////
`timescale 1ns/100ps

module check_burst_slave (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  burst_test_pkg::wb_req_t       i_req,
    output burst_test_pkg::wb_rsp_t       o_rsp,
    output burst_test_pkg::check_data_t   o_check,
    output logic                          o_err
);

    logic ack;
    // Beats acknowledged in the current cycle
    logic [burst_test_pkg::BEAT_W-1:0] beat_q;
    logic err_q;
    logic ena_q;
    logic [63:0] dat_q;
    logic cti_bad;

    ////////////////////////////////////////
    // Beat acceptance
    ////////////////////////////////////////

    // Reads, partial selects, wrap bursts and nonzero base are refused
    assign ack = i_req.cyc && i_req.stb && i_req.we
        && (i_req.sel == burst_test_pkg::SEL_ALL)
        && (i_req.bte == burst_test_pkg::BTE_LINEAR)
        && (i_req.adr == '0);

    // Last beat must end the burst, all others must continue it
    always_comb
    begin
        if (beat_q == burst_test_pkg::LAST_BEAT)
        begin
            cti_bad = (i_req.cti != burst_test_pkg::CTI_END);
        end
        else
        begin
            cti_bad = (i_req.cti != burst_test_pkg::CTI_INC);
        end
    end

    // Beat counter and error pulse
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            beat_q <= '0;
            err_q <= 1'b0;
            ena_q <= 1'b0;
        end
        else
        begin
            // Master delay with stb low just holds the count
            if (!i_req.cyc)
            begin
                beat_q <= '0;
            end
            else if (ack)
            begin
                beat_q <= beat_q + 1'b1;
            end
            err_q <= ack && cti_bad;
            ena_q <= ack;
        end
    end

    // Data word captured on each accepted beat
    always_ff @(posedge i_clk)
    begin
        if (ack)
        begin
            dat_q <= i_req.dat;
        end
    end

    assign o_rsp.ack = ack;
    assign o_rsp.err = err_q;
    assign o_check.ena = ena_q;
    assign o_check.dat = dat_q;
    assign o_err = err_q;

    // Ack only inside a strobed cycle
    a_ack_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rsp.ack |-> i_req.cyc && i_req.stb);

endmodule

//--- hw/pattern_checker.sv
////////////////////////////////////////
// Pattern checker for forwarded burst words
// Word, data error and protocol error counters
////////////////////////////////////////
`timescale 1ns/100ps

module pattern_checker (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  burst_test_pkg::test_ctrl_t    i_ctrl,
    input  burst_test_pkg::check_data_t   i_check,
    input  logic                          i_err,
    output burst_test_pkg::test_status_t  o_status
);

    burst_test_pkg::pattern_word_u word;

    // Expected beat index, wraps every burst
    logic [burst_test_pkg::BEAT_W-1:0] exp_beat_q;
    // Expected burst number per channel
    logic [burst_test_pkg::CHAN_COUNT-1:0][23:0] exp_burst_q;

    logic [31:0] word_cnt_q;
    logic [15:0] data_err_q;
    logic [15:0] prot_err_q;

    logic [burst_test_pkg::CHAN_W-1:0] chan;
    logic tag_ok;
    logic beat_bad;
    logic burst_bad;
    logic data_bad;

    ////////////////////////////////////////
    // Word decode and compare
    ////////////////////////////////////////
    always_comb
    begin
        word.raw = i_check.dat;
    end

    assign tag_ok = (int'(word.pat.chan_tag) < burst_test_pkg::CHAN_COUNT);
    assign chan = word.pat.chan_tag[burst_test_pkg::CHAN_W-1:0];
    assign beat_bad = (word.pat.beat_idx != 32'(exp_beat_q));
    // Burst number only meaningful for a known channel
    assign burst_bad = tag_ok && (word.pat.burst_num != exp_burst_q[chan]);
    assign data_bad = !tag_ok || beat_bad || burst_bad;

    ////////////////////////////////////////
    // Tracking and counters
    ////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            exp_beat_q <= '0;
            exp_burst_q <= '0;
            word_cnt_q <= '0;
            data_err_q <= '0;
            prot_err_q <= '0;
        end
        else
        begin
            if (i_check.ena)
            begin
                word_cnt_q <= word_cnt_q + 32'd1;
                exp_beat_q <= exp_beat_q + 1'b1;
                // Next burst of this channel after its last beat
                if (exp_beat_q == burst_test_pkg::LAST_BEAT && tag_ok)
                begin
                    exp_burst_q[chan] <= exp_burst_q[chan] + 24'd1;
                end
                // Mismatches ignored while checking is off
                if (i_ctrl.check_en && data_bad)
                begin
                    data_err_q <= data_err_q + 16'd1;
                end
            end
            if (i_err)
            begin
                prot_err_q <= prot_err_q + 16'd1;
            end
        end
    end

    assign o_status.word_cnt = word_cnt_q;
    assign o_status.data_err_cnt = data_err_q;
    assign o_status.prot_err_cnt = prot_err_q;

endmodule

//--- hw/burst_test_top.sv
////////////////////////////////////////
// Top level of the burst test path
// Two sources, arbiter, check slave and checker
////////////////////////////////////////
`timescale 1ns/100ps

module burst_test_top (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  logic [burst_test_pkg::CHAN_COUNT-1:0] i_start,
    input  burst_test_pkg::test_ctrl_t            i_ctrl,
    output logic [burst_test_pkg::CHAN_COUNT-1:0] o_done,
    output burst_test_pkg::test_status_t          o_status
);

    // Per-source side of the arbiter
    burst_test_pkg::wb_req_t [burst_test_pkg::CHAN_COUNT-1:0] src_req;
    burst_test_pkg::wb_rsp_t [burst_test_pkg::CHAN_COUNT-1:0] src_rsp;
    logic [burst_test_pkg::CHAN_COUNT-1:0] grant;

    // Shared bus and check path
    burst_test_pkg::wb_req_t bus_req;
    burst_test_pkg::wb_rsp_t bus_rsp;
    burst_test_pkg::check_data_t check;
    logic prot_err;

    // One source per channel
    for (genvar gi = 0; gi < burst_test_pkg::CHAN_COUNT; gi++)
    begin : g_src
        burst_source #(
            .CHAN_ID (gi)
        ) burst_source_inst (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_start (i_start[gi]),
            .i_ctrl  (i_ctrl),
            .i_grant (grant[gi]),
            .i_rsp   (src_rsp[gi]),
            .o_req   (src_req[gi]),
            .o_done  (o_done[gi])
        );
    end

    burst_arbiter burst_arbiter_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (src_req),
        .o_grant (grant),
        .o_req   (bus_req),
        .i_rsp   (bus_rsp),
        .o_rsp   (src_rsp)
    );

    check_burst_slave check_burst_slave_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (bus_req),
        .o_rsp   (bus_rsp),
        .o_check (check),
        .o_err   (prot_err)
    );

    pattern_checker pattern_checker_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ctrl   (i_ctrl),
        .i_check  (check),
        .i_err    (prot_err),
        .o_status (o_status)
    );

endmodule

//--- testbench/tb_burst_test.sv
////////////////////////////////////////
// Testbench for the burst test path
// Clock, reset, LFSR-paced start stimulus
// Scoreboard, concurrent checks, timeout
////////////////////////////////////////
`timescale 1ns/100ps

module tb_burst_test;

    localparam int NUM_CHAN = burst_test_pkg::CHAN_COUNT;
    localparam int BURST_LEN = burst_test_pkg::BURST_LEN;
    // Bursts issued over the whole run
    localparam int NUM_BURSTS = 20;
    localparam int TIMEOUT_CYCLES = NUM_BURSTS * (BURST_LEN + 16) + 200;
    // One done wait may sit behind one queued burst
    localparam int DONE_WAIT = 2 * (BURST_LEN + 16);
    localparam logic [7:0] LFSR_SEED = 8'd49;

    logic i_clk;
    logic i_rst;
    logic [NUM_CHAN-1:0] i_start;
    burst_test_pkg::test_ctrl_t i_ctrl;
    logic [NUM_CHAN-1:0] o_done;
    burst_test_pkg::test_status_t o_status;

    int err_count = 0;
    int cycle_cnt = 0;
    logic [7:0] lfsr_state;

    // Scoreboard state
    logic [31:0] exp_words;
    logic [15:0] exp_data_err;
    logic [15:0] exp_prot_err;
    logic [NUM_CHAN-1:0] busy;
    int done_total;
    int last_done_cyc;
    logic done_seen;

    burst_test_top burst_test_top_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_ctrl   (i_ctrl),
        .o_done   (o_done),
        .o_status (o_status)
    );

    // 100 ns clock
    initial i_clk = 1'b0;
    always #50 i_clk = ~i_clk;

    // Cycle count and run limit
    always @(posedge i_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////
    always @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            exp_words <= '0;
            exp_data_err <= '0;
            exp_prot_err <= '0;
            busy <= '0;
            done_total <= 0;
            last_done_cyc <= 0;
            done_seen <= 1'b0;
        end
        else
        begin
            // Channel busy from accepted start to its done
            for (int c = 0; c < NUM_CHAN; c++)
            begin
                if (o_done[c])
                begin
                    busy[c] <= 1'b0;
                end
                else if (i_start[c])
                begin
                    busy[c] <= 1'b1;
                end
            end
            if (|o_done)
            begin
                // Whole burst lands in the word counter
                exp_words <= exp_words + 32'(BURST_LEN);
                done_total <= done_total + 1;
                last_done_cyc <= cycle_cnt;
                done_seen <= 1'b1;
                // One bad beat per faulted burst, only when checked
                if (o_done[i_ctrl.fault_chan] && i_ctrl.inj_data && i_ctrl.check_en)
                begin
                    exp_data_err <= exp_data_err + 16'd1;
                end
                // Bad cycle type on the last beat
                if (o_done[i_ctrl.fault_chan] && i_ctrl.inj_cti)
                begin
                    exp_prot_err <= exp_prot_err + 16'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////

    // Counters settle the cycle after done
    a_word_cnt: assert property (@(posedge i_clk) disable iff (i_rst)
        (|o_done) |=> (o_status.word_cnt == exp_words))
    else
    begin
        err_count++;
        $display("MISMATCH time=%0t o_status.word_cnt got=%0d exp=%0d", $time,
            $sampled(o_status.word_cnt), $sampled(exp_words));
    end

    a_data_err: assert property (@(posedge i_clk) disable iff (i_rst)
        (|o_done) |=> (o_status.data_err_cnt == exp_data_err))
    else
    begin
        err_count++;
        $display("MISMATCH time=%0t o_status.data_err_cnt got=%0d exp=%0d", $time,
            $sampled(o_status.data_err_cnt), $sampled(exp_data_err));
    end

    a_prot_err: assert property (@(posedge i_clk) disable iff (i_rst)
        (|o_done) |=> (o_status.prot_err_cnt == exp_prot_err))
    else
    begin
        err_count++;
        $display("MISMATCH time=%0t o_status.prot_err_cnt got=%0d exp=%0d", $time,
            $sampled(o_status.prot_err_cnt), $sampled(exp_prot_err));
    end

    // Shared bus means bursts never overlap
    a_done_gap: assert property (@(posedge i_clk) disable iff (i_rst)
        (|o_done) && done_seen |-> (cycle_cnt - last_done_cyc >= BURST_LEN))
    else
    begin
        err_count++;
        $display("Two done pulses less than one burst apart at %0t", $time);
    end

    for (genvar gc = 0; gc < NUM_CHAN; gc++)
    begin : g_chan_chk
        a_done_pending: assert property (@(posedge i_clk) disable iff (i_rst)
            o_done[gc] |-> busy[gc])
        else
        begin
            err_count++;
            $display("Channel %0d gave a done with no burst pending at %0t", gc, $time);
        end

        a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
            o_done[gc] |=> !o_done[gc])
        else
        begin
            err_count++;
            $display("Channel %0d held done longer than one cycle at %0t", gc, $time);
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic set_ctrl(input logic chk, input logic chan, input logic dat, input logic cti);
        @(posedge i_clk);
        i_ctrl <= '{check_en: chk, fault_chan: chan, inj_data: dat, inj_cti: cti};
    endtask

    task automatic pulse_start(input logic [NUM_CHAN-1:0] mask);
        @(posedge i_clk);
        i_start <= mask;
        @(posedge i_clk);
        i_start <= '0;
    endtask

    // Done sampled mid-cycle
    task automatic wait_done(input int ch);
        int n;
        logic got;
        n = 0;
        got = 1'b0;
        while (!got && n < DONE_WAIT)
        begin
            @(negedge i_clk);
            got = o_done[ch];
            n++;
        end
        if (!got)
        begin
            err_count++;
            $display("No done from channel %0d within %0d cycles", ch, DONE_WAIT);
        end
    endtask

    task automatic wait_all_done();
        int n;
        logic [NUM_CHAN-1:0] seen;
        n = 0;
        seen = '0;
        while (seen != '1 && n < 3 * DONE_WAIT)
        begin
            @(negedge i_clk);
            seen = seen | o_done;
            n++;
        end
        if (seen != '1)
        begin
            err_count++;
            $display("Missing done after simultaneous starts, seen mask %b", seen);
        end
    endtask

    task automatic run_burst(input int ch);
        pulse_start(NUM_CHAN'(1) << ch);
        wait_done(ch);
    endtask

    task automatic check_final();
        assert (o_status.word_cnt == exp_words)
        else
        begin
            err_count++;
            $display("MISMATCH time=%0t o_status.word_cnt got=%0d exp=%0d", $time,
                o_status.word_cnt, exp_words);
        end
        assert (done_total == NUM_BURSTS)
        else
        begin
            err_count++;
            $display("Saw %0d done pulses where %0d bursts were started", done_total,
                NUM_BURSTS);
        end
        assert (busy == '0)
        else
        begin
            err_count++;
            $display("A burst was still pending at the end of the run");
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        int first;
        int gap;
        i_rst <= 1'b1;
        i_start <= '0;
        i_ctrl <= '0;
        lfsr_state = LFSR_SEED;
        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;

        // Clean burst per channel
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        run_burst(0);
        run_burst(1);

        // Both start together, served in turn
        pulse_start('1);
        wait_all_done();

        // Random first channel and short gap
        for (int r = 0; r < 3; r++)
        begin
            take_bits(1, first);
            take_bits(3, gap);
            pulse_start(NUM_CHAN'(1) << first);
            repeat (gap) @(posedge i_clk);
            pulse_start(NUM_CHAN'(1) << (1 - first));
            wait_all_done();
        end

        // Data fault counted, then ignored with checking off
        set_ctrl(1'b1, 1'b1, 1'b1, 1'b0);
        run_burst(1);
        set_ctrl(1'b0, 1'b0, 1'b1, 1'b0);
        run_burst(0);

        // Cycle type fault on the last beat
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b1);
        run_burst(0);

        // Repeats on channel 0 around channel 1 bursts
        set_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
        for (int r = 0; r < 2; r++)
        begin
            run_burst(0);
            run_burst(0);
            run_burst(1);
        end

        // Second start while busy is dropped
        pulse_start(2'b01);
        repeat (5) @(posedge i_clk);
        pulse_start(2'b01);
        wait_done(0);

        repeat (32) @(negedge i_clk);
        check_final();

        $display("Summary: %0d errors, %0d words, %0d data errors, %0d protocol errors",
            err_count, o_status.word_cnt, o_status.data_err_cnt, o_status.prot_err_cnt);
        if (err_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/burst_test_pkg.sv
hw/burst_source.sv
hw/burst_arbiter.sv
hw/check_burst_slave.sv
hw/pattern_checker.sv
hw/burst_test_top.sv
testbench/tb_burst_test.sv

//--- Makefile
# Verilator build and run for the burst test path

VERILATOR ?= verilator
TOP       ?= tb_burst_test
RTL_TOP   ?= burst_test_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the log
sim: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
